/* src.f */
+incdir+include
verilog/rename_pkg.sv
verilog/free_list.sv
verilog/map_table.sv
verilog/commit_map.sv
verilog/rename_stage.sv
verilog/rename_top.sv
bench/rename_assertions.sv
bench/rename_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rename_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Keep running after an assertion so the closing report still prints
run: compile
	@out="$$(./$(SIM) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

/* bench/rename_tb.sv */
// Register rename testbench

`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

module rename_tb;

    logic                  clk;
    logic                  reset;
    logic                  in_valid;
    rename_pkg::arch_idx_t in_src1;
    rename_pkg::arch_idx_t in_src2;
    rename_pkg::arch_idx_t in_dest;
    logic                  in_has_dest;
    logic                  in_ready;
    logic                  out_valid;
    rename_pkg::phys_tag_t out_src1_tag;
    rename_pkg::phys_tag_t out_src2_tag;
    rename_pkg::phys_tag_t out_dest_tag;
    rename_pkg::phys_tag_t out_old_tag;
    logic                  out_has_dest;
    logic                  out_ready;
    logic                  retire_en;
    rename_pkg::arch_idx_t retire_dest;
    rename_pkg::phys_tag_t retire_tag;

    // Reference model state
    rename_pkg::phys_tag_t spec_map [`ARCH_REGS];
    rename_pkg::phys_tag_t done_map [`ARCH_REGS];
    rename_pkg::phys_tag_t free_q [$];
    // Renamed destinations in program order, arch index above the tag
    logic [10:0]           inflight_q [$];
    // Expected output record {src1, src2, dest, old, has_dest}
    logic [24:0]           expect_q [$];

    logic [24:0]           exp_rec;
    logic                  exp_ready;
    rename_pkg::phys_tag_t new_tag;
    logic [31:0]           rnd;
    logic [10:0]           retire_entry;
    int                    value_errors;
    int                    seed;
    string                 test_name;

    rename_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Planned sequences take a few hundred cycles
    initial begin
        repeat (2000) @(posedge clk);
        $display("Watchdog expired, the DUT stopped accepting or draining");
        $display("Test FAILED");
        $finish;
    end

    task automatic compare_value(input string field, input logic [24:0] exp_val,
                                 input logic [24:0] act_val);
        if (exp_val !== act_val) begin
            value_errors++;
            $display("CHECK FAILED %s %s expected %h actual %h",
                     test_name, field, exp_val, act_val);
        end
    endtask

    function automatic rename_pkg::arch_idx_t rand_arch();
        return rename_pkg::arch_idx_t'($random(seed));
    endfunction

    // Hold the instruction until the edge that takes it
    task automatic issue(input rename_pkg::arch_idx_t s1, input rename_pkg::arch_idx_t s2,
                         input rename_pkg::arch_idx_t d, input logic has_dest);
        in_valid    <= 1'b1;
        in_src1     <= s1;
        in_src2     <= s2;
        in_dest     <= d;
        in_has_dest <= has_dest;
        do begin
            @(posedge clk);
        end while (!in_ready);
        in_valid <= 1'b0;
    endtask

    // Retire the oldest renamed destination for one cycle
    task automatic retire_oldest();
        logic [10:0] entry;
        entry = inflight_q.pop_front();
        retire_en   <= 1'b1;
        retire_dest <= entry[10:6];
        retire_tag  <= entry[5:0];
        @(posedge clk);
        retire_en <= 1'b0;
    endtask

    // Model runs on the falling edge and predicts the next rising edge
    always @(negedge clk) begin
        if (!reset) begin
            compare_value("out_valid", 25'(expect_q.size() != 0), 25'(out_valid));
            if (expect_q.size() != 0 && out_ready) begin
                exp_rec = expect_q.pop_front();
                compare_value("renamed", exp_rec, {out_src1_tag, out_src2_tag,
                    out_has_dest ? out_dest_tag : 6'd0,
                    out_has_dest ? out_old_tag : 6'd0, out_has_dest});
            end
            // Released tag joins the tail before the head is taken
            if (retire_en) begin
                free_q.push_back(done_map[retire_dest]);
                done_map[retire_dest] = retire_tag;
            end
            exp_ready = (expect_q.size() == 0) && (!in_has_dest || free_q.size() != 0);
            if (in_valid) begin
                compare_value("in_ready", 25'(exp_ready), 25'(in_ready));
            end
            if (in_valid && exp_ready && in_has_dest) begin
                new_tag = free_q.pop_front();
                expect_q.push_back({spec_map[in_src1], spec_map[in_src2], new_tag,
                                    spec_map[in_dest], 1'b1});
                inflight_q.push_back({in_dest, new_tag});
                spec_map[in_dest] = new_tag;
            end else if (in_valid && exp_ready) begin
                expect_q.push_back({spec_map[in_src1], spec_map[in_src2], 12'd0, 1'b0});
            end
        end
    end

    initial begin
        seed         = 32'h35f5_3e1e;
        value_errors = 0;
        test_name    = "reset";
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_src1      = '0;
        in_src2      = '0;
        in_dest      = '0;
        in_has_dest  = 1'b0;
        out_ready    = 1'b1;
        retire_en    = 1'b0;
        retire_dest  = '0;
        retire_tag   = '0;
        // Identity maps and tags 32 to 63 free
        for (int i = 0; i < `ARCH_REGS; i++) begin
            spec_map[i] = rename_pkg::phys_tag_t'(i);
            done_map[i] = rename_pkg::phys_tag_t'(i);
        end
        for (int i = 0; i < `PHYS_REGS - `ARCH_REGS; i++) begin
            free_q.push_back(rename_pkg::phys_tag_t'(`ARCH_REGS + i));
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        test_name = "alloc_order";
        repeat (32) issue(rand_arch(), rand_arch(), rand_arch(), 1'b1);
        test_name = "source_lookup";
        repeat (4) issue(rand_arch(), rand_arch(), rand_arch(), 1'b0);
        // List is empty now but a rename without destination still goes
        test_name = "exhaustion";
        issue(5'd6, 5'd7, 5'd0, 1'b0);

        // Rename waits on an empty list until the retire releases a tag
        test_name = "forwarding";
        fork
            issue(5'd1, 5'd2, 5'd9, 1'b1);
            begin
                repeat (4) @(posedge clk);
                retire_oldest();
            end
        join

        test_name = "release_reuse";
        repeat (12) retire_oldest();
        repeat (8) issue(rand_arch(), rand_arch(), rand_arch(), 1'b1);

        test_name = "back_pressure";
        out_ready <= 1'b0;
        fork
            repeat (3) issue(rand_arch(), rand_arch(), rand_arch(), 1'b1);
            begin
                repeat (6) @(posedge clk);
                out_ready <= 1'b1;
            end
        join

        // Random traffic with retires kept behind the renames
        test_name = "random_mix";
        repeat (300) begin
            rnd = $random(seed);
            out_ready   <= rnd[0] | rnd[1];
            in_valid    <= rnd[2];
            in_has_dest <= rnd[3] | rnd[4];
            in_src1     <= rnd[10:6];
            in_src2     <= rnd[15:11];
            in_dest     <= rnd[20:16];
            if (rnd[5] && inflight_q.size() > 1) begin
                retire_entry = inflight_q.pop_front();
                retire_en   <= 1'b1;
                retire_dest <= retire_entry[10:6];
                retire_tag  <= retire_entry[5:0];
            end else begin
                retire_en <= 1'b0;
            end
            @(posedge clk);
        end
        in_valid  <= 1'b0;
        retire_en <= 1'b0;
        out_ready <= 1'b1;
        repeat (4) @(posedge clk);

        $display("value errors %0d, assertion errors %0d",
                 value_errors, u_dut.u_assertions.assert_errors);
        if (value_errors == 0 && u_dut.u_assertions.assert_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/rename_assertions.sv */
// Rename checks

`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

module rename_assertions (
    input logic                  clk,
    input logic                  reset,
    input logic                  in_ready,
    input logic                  in_has_dest,
    input logic                  out_valid,
    input logic                  out_ready,
    input rename_pkg::phys_tag_t out_src1_tag,
    input rename_pkg::phys_tag_t out_src2_tag,
    input rename_pkg::phys_tag_t out_dest_tag,
    input rename_pkg::phys_tag_t out_old_tag,
    input logic                  out_has_dest,
    input logic                  release_en,
    input rename_pkg::fl_ptr_t   fl_head,
    input rename_pkg::fl_ptr_t   fl_tail
);

    // Count of failed assertions
    int assert_errors = 0;

    // Stalled output keeps every field until the consumer takes it
    output_hold: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_src1_tag)
            && $stable(out_src2_tag) && $stable(out_dest_tag)
            && $stable(out_old_tag) && $stable(out_has_dest)))
    else begin
        assert_errors++;
        $error("renamed output changed while out_ready was low");
    end

    // Readiness for a destination against the ring state itself
    // Equal pointers leave only a release to supply the tag
    ready_needs_tag: assert property (@(posedge clk) disable iff (reset)
        (in_ready && in_has_dest && (fl_head == fl_tail)) |-> release_en)
    else begin
        assert_errors++;
        $error("in_ready high with no free tag for the destination");
    end

    // Ring pointers stay inside the slot array
    pointer_range: assert property (@(posedge clk) disable iff (reset)
        (fl_head < rename_pkg::fl_ptr_t'(`FREE_LIST_SIZE))
            && (fl_tail < rename_pkg::fl_ptr_t'(`FREE_LIST_SIZE)))
    else begin
        assert_errors++;
        $error("free list pointer outside the slot range");
    end

endmodule

// Attached to the top level
// Ring pointers are taken from inside the free list
bind rename_top rename_assertions u_assertions (
    .clk          (clk),
    .reset        (reset),
    .in_ready     (in_ready),
    .in_has_dest  (in_has_dest),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_src1_tag (out_src1_tag),
    .out_src2_tag (out_src2_tag),
    .out_dest_tag (out_dest_tag),
    .out_old_tag  (out_old_tag),
    .out_has_dest (out_has_dest),
    .release_en   (release_en),
    .fl_head      (u_free_list.head),
    .fl_tail      (u_free_list.tail)
);

`default_nettype wire

/* verilog/rename_top.sv */
// Register rename top

`timescale 1ns/1ps
`default_nettype none

module rename_top (
    input  logic                  clk,
    input  logic                  reset,

    // Rename input
    input  logic                  in_valid,
    input  rename_pkg::arch_idx_t in_src1,
    input  rename_pkg::arch_idx_t in_src2,
    input  rename_pkg::arch_idx_t in_dest,
    input  logic                  in_has_dest,
    output logic                  in_ready,

    // Rename output
    output logic                  out_valid,
    output rename_pkg::phys_tag_t out_src1_tag,
    output rename_pkg::phys_tag_t out_src2_tag,
    output rename_pkg::phys_tag_t out_dest_tag,
    output rename_pkg::phys_tag_t out_old_tag,
    output logic                  out_has_dest,
    input  logic                  out_ready,

    // Retire port
    input  logic                  retire_en,
    input  rename_pkg::arch_idx_t retire_dest,
    input  rename_pkg::phys_tag_t retire_tag
);

    // Stage to speculative map
    rename_pkg::arch_idx_t rd_idx1;
    rename_pkg::arch_idx_t rd_idx2;
    rename_pkg::phys_tag_t rd_tag1;
    rename_pkg::phys_tag_t rd_tag2;
    logic                  wr_en;
    rename_pkg::arch_idx_t wr_idx;
    rename_pkg::phys_tag_t wr_tag;
    rename_pkg::phys_tag_t old_tag;

    // Free list traffic
    logic                  alloc_en;
    rename_pkg::phys_tag_t alloc_tag;
    logic                  empty;
    logic                  release_en;
    rename_pkg::phys_tag_t release_tag;

    rename_stage u_stage (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_src1      (in_src1),
        .in_src2      (in_src2),
        .in_dest      (in_dest),
        .in_has_dest  (in_has_dest),
        .in_ready     (in_ready),
        .out_valid    (out_valid),
        .out_src1_tag (out_src1_tag),
        .out_src2_tag (out_src2_tag),
        .out_dest_tag (out_dest_tag),
        .out_old_tag  (out_old_tag),
        .out_has_dest (out_has_dest),
        .out_ready    (out_ready),
        .rd_idx1      (rd_idx1),
        .rd_idx2      (rd_idx2),
        .rd_tag1      (rd_tag1),
        .rd_tag2      (rd_tag2),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .wr_tag       (wr_tag),
        .old_tag      (old_tag),
        .alloc_en     (alloc_en),
        .alloc_tag    (alloc_tag),
        .empty        (empty),
        .release_en   (release_en)
    );

    map_table u_map (
        .clk     (clk),
        .reset   (reset),
        .rd_idx1 (rd_idx1),
        .rd_idx2 (rd_idx2),
        .rd_tag1 (rd_tag1),
        .rd_tag2 (rd_tag2),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_tag  (wr_tag),
        .old_tag (old_tag)
    );

    commit_map u_commit (
        .clk         (clk),
        .reset       (reset),
        .retire_en   (retire_en),
        .retire_dest (retire_dest),
        .retire_tag  (retire_tag),
        .release_en  (release_en),
        .release_tag (release_tag)
    );

    free_list u_free_list (
        .clk         (clk),
        .reset       (reset),
        .alloc_en    (alloc_en),
        .alloc_tag   (alloc_tag),
        .empty       (empty),
        .release_en  (release_en),
        .release_tag (release_tag)
    );

endmodule

`default_nettype wire

/* verilog/rename_stage.sv */
// Rename pipeline stage

`timescale 1ns/1ps
`default_nettype none

module rename_stage (
    input  logic                  clk,
    input  logic                  reset,

    // Incoming instruction
    input  logic                  in_valid,
    input  rename_pkg::arch_idx_t in_src1,
    input  rename_pkg::arch_idx_t in_src2,
    input  rename_pkg::arch_idx_t in_dest,
    input  logic                  in_has_dest,
    output logic                  in_ready,

    // Renamed instruction
    output logic                  out_valid,
    output rename_pkg::phys_tag_t out_src1_tag,
    output rename_pkg::phys_tag_t out_src2_tag,
    output rename_pkg::phys_tag_t out_dest_tag,
    output rename_pkg::phys_tag_t out_old_tag,
    output logic                  out_has_dest,
    input  logic                  out_ready,

    // Speculative map access
    output rename_pkg::arch_idx_t rd_idx1,
    output rename_pkg::arch_idx_t rd_idx2,
    input  rename_pkg::phys_tag_t rd_tag1,
    input  rename_pkg::phys_tag_t rd_tag2,
    output logic                  wr_en,
    output rename_pkg::arch_idx_t wr_idx,
    output rename_pkg::phys_tag_t wr_tag,
    input  rename_pkg::phys_tag_t old_tag,

    // Free list access
    output logic                  alloc_en,
    input  rename_pkg::phys_tag_t alloc_tag,
    input  logic                  empty,
    input  logic                  release_en
);

    logic slot_free;
    logic tag_avail;
    logic accept;

    // Output register empty or leaving this cycle
    assign slot_free = !out_valid || out_ready;

    // A release this cycle gets forwarded by the free list
    assign tag_avail = !empty || release_en;

    // Instructions without a destination never wait on the free list
    assign in_ready = slot_free && (!in_has_dest || tag_avail);
    assign accept   = in_valid && in_ready;

    // Map lookup straight from the incoming fields
    assign rd_idx1 = in_src1;
    assign rd_idx2 = in_src2;

    // Allocate and remap only for real destinations
    assign alloc_en = accept && in_has_dest;
    assign wr_en    = alloc_en;
    assign wr_idx   = in_dest;
    assign wr_tag   = alloc_tag;

    // Valid bit of the output register
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Payload only moves on acceptance, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (accept) begin
            out_src1_tag <= rd_tag1;
            out_src2_tag <= rd_tag2;
            out_has_dest <= in_has_dest;
            // Tags read as zero when there is no destination
            out_dest_tag <= in_has_dest ? alloc_tag : '0;
            out_old_tag  <= in_has_dest ? old_tag : '0;
        end
    end

endmodule

`default_nettype wire

/* verilog/commit_map.sv */
// Retired rename map

`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

module commit_map (
    input  logic                  clk,
    input  logic                  reset,

    // One retiring instruction per cycle
    input  logic                  retire_en,
    input  rename_pkg::arch_idx_t retire_dest,
    input  rename_pkg::phys_tag_t retire_tag,

    // Tag no longer reachable by any in-flight or retired state
    output logic                  release_en,
    output rename_pkg::phys_tag_t release_tag
);

    // Architectural state as of the last retirement
    rename_pkg::phys_tag_t map [`ARCH_REGS];

    // The replaced entry is dead once the new mapping retires
    assign release_en  = retire_en;
    assign release_tag = map[retire_dest];

    always_ff @(posedge clk) begin
        if (reset) begin
            // Same starting point as the speculative map
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map[i] <= rename_pkg::phys_tag_t'(i);
            end
        end else if (retire_en) begin
            map[retire_dest] <= retire_tag;
        end
    end

endmodule

`default_nettype wire

/* verilog/map_table.sv */
// Speculative rename map

`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

module map_table (
    input  logic                  clk,
    input  logic                  reset,

    // Source operand lookups
    input  rename_pkg::arch_idx_t rd_idx1,
    input  rename_pkg::arch_idx_t rd_idx2,
    output rename_pkg::phys_tag_t rd_tag1,
    output rename_pkg::phys_tag_t rd_tag2,

    // Destination update
    input  logic                  wr_en,
    input  rename_pkg::arch_idx_t wr_idx,
    input  rename_pkg::phys_tag_t wr_tag,

    // Mapping the destination held before this write
    output rename_pkg::phys_tag_t old_tag
);

    // One physical tag per architectural register
    rename_pkg::phys_tag_t map [`ARCH_REGS];

    // Reads see the state before the current edge
    // A source equal to the destination still gets the older tag
    assign rd_tag1 = map[rd_idx1];
    assign rd_tag2 = map[rd_idx2];

    // Previous owner of the destination, goes with the instruction
    assign old_tag = map[wr_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            // Identity map, register i lives in tag i
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map[i] <= rename_pkg::phys_tag_t'(i);
            end
        end else if (wr_en) begin
            // Next instruction sees the new tag
            map[wr_idx] <= wr_tag;
        end
    end

endmodule

`default_nettype wire

/* verilog/free_list.sv */
// Physical tag free list

`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

module free_list (
    input  logic                 clk,
    input  logic                 reset,

    // Allocation side, head of the queue
    input  logic                 alloc_en,
    output rename_pkg::phys_tag_t alloc_tag,
    output logic                 empty,

    // Release side, tail of the queue
    input  logic                 release_en,
    input  rename_pkg::phys_tag_t release_tag
);

    // Tag storage, one slot is always left unused
    rename_pkg::phys_tag_t slots [`FREE_LIST_SIZE];

    // Head is the next tag handed out
    rename_pkg::fl_ptr_t head;
    // Tail is the first unused slot
    rename_pkg::fl_ptr_t tail;

    logic bypass;

    // Step a pointer around the ring
    function automatic rename_pkg::fl_ptr_t next_ptr(input rename_pkg::fl_ptr_t ptr);
        if (ptr == rename_pkg::fl_ptr_t'(`FREE_LIST_SIZE - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty = (head == tail);

    // Empty queue with a release in flight hands the released tag straight out
    assign alloc_tag = (empty && release_en) ? release_tag : slots[head];

    // Forwarded allocation leaves both pointers alone
    assign bypass = empty && release_en && alloc_en;

    always_ff @(posedge clk) begin
        if (reset) begin
            // Tags above the architectural range start out free
            for (int i = 0; i < `PHYS_REGS - `ARCH_REGS; i++) begin
                slots[i] <= rename_pkg::phys_tag_t'(`ARCH_REGS + i);
            end
            head <= '0;
            tail <= rename_pkg::fl_ptr_t'(`PHYS_REGS - `ARCH_REGS);
        end else if (!bypass) begin
            // Pop the head
            // The stage never allocates from an empty list without a release
            if (alloc_en && !empty) begin
                head <= next_ptr(head);
            end
            // Push at the tail
            // No full check, released tags never outnumber the tags in use
            if (release_en) begin
                slots[tail] <= release_tag;
                tail <= next_ptr(tail);
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/rename_pkg.sv */
// Rename shared types

`default_nettype none

`include "rename_params.svh"

package rename_pkg;

    // Architectural register number
    typedef logic [`ARCH_IDX_SZ-1:0] arch_idx_t;

    // Physical register tag
    typedef logic [`PHYS_IDX_SZ-1:0] phys_tag_t;

    // Slot pointer into the circular free list
    // 6 bits cover the 33 slots
    typedef logic [$clog2(`FREE_LIST_SIZE)-1:0] fl_ptr_t;

endpackage

`default_nettype wire

/* include/rename_params.svh */
// Rename sizing parameters

`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// Architectural register file seen by software
`define ARCH_REGS 32

// Physical register file behind the rename map
`define PHYS_REGS 64

// Index widths for the two register spaces
`define ARCH_IDX_SZ 5
`define PHYS_IDX_SZ 6

// Free list holds every non-architectural tag
// Plus one slot so that full and empty never look alike
`define FREE_LIST_SIZE 33

`endif
